// ==== compile.f ====
src/psg_audio_pkg.sv
src/psg_bus_pkg.sv
src/psg_reg_ctrl.sv
src/psg_tone_bank.sv
src/psg_mixer.sv
src/sigma_delta_dac.sv
src/psg_audio_top.sv
tb/tb_clk_gen.sv
tb/tb_psg_audio.sv

// ==== src/psg_audio_pkg.sv ====
package psg_audio_pkg;

  // Three tone channels, fixed by the register map
  localparam int NUM_CH = 3;

  // Tone period counter width
  localparam int PERIOD_BITS = 12;

  // Linear volume, also the width of the enable mask register
  localparam int VOL_BITS = 4;

  // Unsigned PCM word out of the mixer
  localparam int PCM_BITS = 8;

  // Sum of all channel volumes at full scale, times four
  localparam int PCM_MAX = NUM_CH * ((1 << VOL_BITS) - 1) * 4;

endpackage

// ==== src/psg_audio_top.sv ====
`timescale 1ns/1ns

module psg_audio_top #(
  parameter int TICK_DIV = 8, // sys_clk cycles per tone tick
  parameter int DAC_DIV  = 2  // sys_clk cycles per DAC update
) (
  input  logic                                  sys_clk,
  input  logic                                  i_rst_n,
  input  logic                                  i_cyc,
  input  logic                                  i_stb,
  input  logic                                  i_we,
  input  logic [psg_bus_pkg::ADDR_BITS-1:0]     i_adr,
  input  logic [psg_bus_pkg::BUS_DATA_BITS-1:0] i_dat,
  output logic [psg_bus_pkg::BUS_DATA_BITS-1:0] o_dat,
  output logic                                  o_ack,
  output logic                                  o_audio,
  output logic [psg_audio_pkg::PCM_BITS-1:0]    o_pcm
);
  import psg_audio_pkg::*;

  logic                   tone_tick;
  logic                   dac_tick;
  logic [PERIOD_BITS-1:0] period_a;
  logic [PERIOD_BITS-1:0] period_b;
  logic [PERIOD_BITS-1:0] period_c;
  logic [NUM_CH-1:0]      ch_enable;
  logic [VOL_BITS-1:0]    vol_a;
  logic [VOL_BITS-1:0]    vol_b;
  logic [VOL_BITS-1:0]    vol_c;
  logic [NUM_CH-1:0]      square;
  logic [PCM_BITS-1:0]    pcm;

  psg_reg_ctrl #(
    .TICK_DIV (TICK_DIV),
    .DAC_DIV  (DAC_DIV)
  ) psg_reg_ctrl_i (
    .sys_clk     (sys_clk),
    .i_rst_n     (i_rst_n),
    .i_cyc       (i_cyc),
    .i_stb       (i_stb),
    .i_we        (i_we),
    .i_adr       (i_adr),
    .i_dat       (i_dat),
    .o_dat       (o_dat),
    .o_ack       (o_ack),
    .o_tone_tick (tone_tick),
    .o_dac_tick  (dac_tick),
    .o_period_a  (period_a),
    .o_period_b  (period_b),
    .o_period_c  (period_c),
    .o_ch_enable (ch_enable),
    .o_vol_a     (vol_a),
    .o_vol_b     (vol_b),
    .o_vol_c     (vol_c)
  );

  psg_tone_bank psg_tone_bank_i (
    .sys_clk     (sys_clk),
    .i_rst_n     (i_rst_n),
    .i_tone_tick (tone_tick),
    .i_period_a  (period_a),
    .i_period_b  (period_b),
    .i_period_c  (period_c),
    .o_square    (square)
  );

  psg_mixer psg_mixer_i (
    .sys_clk     (sys_clk),
    .i_rst_n     (i_rst_n),
    .i_square    (square),
    .i_ch_enable (ch_enable),
    .i_vol_a     (vol_a),
    .i_vol_b     (vol_b),
    .i_vol_c     (vol_c),
    .o_pcm       (pcm)
  );

  // One-bit audio pin
  sigma_delta_dac sigma_delta_dac_i (
    .sys_clk    (sys_clk),
    .i_rst_n    (i_rst_n),
    .i_dac_tick (dac_tick),
    .i_pcm      (pcm),
    .o_audio    (o_audio)
  );

  assign o_pcm = pcm; // Exported for simulation

endmodule

// ==== src/psg_bus_pkg.sv ====
package psg_bus_pkg;

  localparam int BUS_DATA_BITS = 32;
  localparam int ADDR_BITS     = 3; // Word address into the register file

  // Register map
  localparam logic [ADDR_BITS-1:0] ADDR_TONE_A = 3'd0;
  localparam logic [ADDR_BITS-1:0] ADDR_TONE_B = 3'd1;
  localparam logic [ADDR_BITS-1:0] ADDR_TONE_C = 3'd2;
  localparam logic [ADDR_BITS-1:0] ADDR_ENABLE = 3'd3;
  localparam logic [ADDR_BITS-1:0] ADDR_VOL_A  = 3'd4;
  localparam logic [ADDR_BITS-1:0] ADDR_VOL_B  = 3'd5;
  localparam logic [ADDR_BITS-1:0] ADDR_VOL_C  = 3'd6;

  // Tone period registers
  typedef struct packed {
    logic [BUS_DATA_BITS-psg_audio_pkg::PERIOD_BITS-1:0] rsvd;
    logic [psg_audio_pkg::PERIOD_BITS-1:0]               period;
  } tone_view_t;

  // Volume and enable mask registers
  typedef struct packed {
    logic [BUS_DATA_BITS-psg_audio_pkg::VOL_BITS-1:0] rsvd;
    logic [psg_audio_pkg::VOL_BITS-1:0]               level;
  } level_view_t;

  // One bus word, read as either view depending on the address
  typedef union packed {
    tone_view_t  tone;
    level_view_t lvl;
  } reg_word_u;

endpackage

// ==== src/psg_mixer.sv ====
`timescale 1ns/1ns

module psg_mixer (
  input  logic                               sys_clk,
  input  logic                               i_rst_n,
  input  logic [psg_audio_pkg::NUM_CH-1:0]   i_square,
  input  logic [psg_audio_pkg::NUM_CH-1:0]   i_ch_enable,
  input  logic [psg_audio_pkg::VOL_BITS-1:0] i_vol_a,
  input  logic [psg_audio_pkg::VOL_BITS-1:0] i_vol_b,
  input  logic [psg_audio_pkg::VOL_BITS-1:0] i_vol_c,
  output logic [psg_audio_pkg::PCM_BITS-1:0] o_pcm
);
  import psg_audio_pkg::*;

  // Sum before the times-four scaling
  localparam int SUM_BITS = PCM_BITS - 2;

  logic [VOL_BITS-1:0] vol [NUM_CH];
  logic [SUM_BITS-1:0] level_sum;

  assign vol[0] = i_vol_a;
  assign vol[1] = i_vol_b;
  assign vol[2] = i_vol_c;

  always_comb begin
    level_sum = '0;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      if (i_ch_enable[ch] && i_square[ch]) begin
        level_sum = level_sum + SUM_BITS'(vol[ch]);
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!i_rst_n) begin
      o_pcm <= '0;
    end else begin
      o_pcm <= {level_sum, 2'b00}; // Scale by four
    end
  end

  // Full-scale bound from the register widths feeding this block
  a_pcm_range: assert property (@(posedge sys_clk) disable iff (!i_rst_n)
    o_pcm <= PCM_BITS'(PCM_MAX));

endmodule

// ==== src/psg_reg_ctrl.sv ====
`timescale 1ns/1ns

module psg_reg_ctrl #(
  parameter int TICK_DIV = 8,
  parameter int DAC_DIV  = 2
) (
  input  logic                                    sys_clk,
  input  logic                                    i_rst_n,
  input  logic                                    i_cyc,
  input  logic                                    i_stb,
  input  logic                                    i_we,
  input  logic [psg_bus_pkg::ADDR_BITS-1:0]       i_adr,
  input  logic [psg_bus_pkg::BUS_DATA_BITS-1:0]   i_dat,
  output logic [psg_bus_pkg::BUS_DATA_BITS-1:0]   o_dat,
  output logic                                    o_ack,
  output logic                                    o_tone_tick,
  output logic                                    o_dac_tick,
  output logic [psg_audio_pkg::PERIOD_BITS-1:0]   o_period_a,
  output logic [psg_audio_pkg::PERIOD_BITS-1:0]   o_period_b,
  output logic [psg_audio_pkg::PERIOD_BITS-1:0]   o_period_c,
  output logic [psg_audio_pkg::NUM_CH-1:0]        o_ch_enable,
  output logic [psg_audio_pkg::VOL_BITS-1:0]      o_vol_a,
  output logic [psg_audio_pkg::VOL_BITS-1:0]      o_vol_b,
  output logic [psg_audio_pkg::VOL_BITS-1:0]      o_vol_c
);
  import psg_bus_pkg::*;
  import psg_audio_pkg::*;

  localparam int TICK_BITS = $clog2(TICK_DIV);
  localparam int DAC_BITS  = (DAC_DIV > 1) ? $clog2(DAC_DIV) : 1;

  logic                 req;
  reg_word_u            wr_word;
  reg_word_u            rd_word;
  logic [VOL_BITS-1:0]  enable_mask; // Full 4 bits kept for readback
  logic [TICK_BITS-1:0] tick_cnt;
  logic                 tick_wrap;
  logic [DAC_BITS-1:0]  dac_cnt;
  logic                 dac_wrap;

  assign req     = i_cyc & i_stb;
  assign wr_word = i_dat;

  assign o_ch_enable = enable_mask[NUM_CH-1:0];

  // Register writes land on the edge that raises ack
  always_ff @(posedge sys_clk) begin
    if (!i_rst_n) begin
      o_period_a  <= '0;
      o_period_b  <= '0;
      o_period_c  <= '0;
      enable_mask <= '0;
      o_vol_a     <= '0;
      o_vol_b     <= '0;
      o_vol_c     <= '0;
    end else if (req && i_we) begin
      case (i_adr)
        ADDR_TONE_A: o_period_a  <= wr_word.tone.period;
        ADDR_TONE_B: o_period_b  <= wr_word.tone.period;
        ADDR_TONE_C: o_period_c  <= wr_word.tone.period;
        ADDR_ENABLE: enable_mask <= wr_word.lvl.level;
        ADDR_VOL_A:  o_vol_a     <= wr_word.lvl.level;
        ADDR_VOL_B:  o_vol_b     <= wr_word.lvl.level;
        ADDR_VOL_C:  o_vol_c     <= wr_word.lvl.level;
        default: ; // Unmapped, dropped
      endcase
    end
  end

  // Zero-extended readback
  always_comb begin
    rd_word = '0;
    case (i_adr)
      ADDR_TONE_A: rd_word.tone.period = o_period_a;
      ADDR_TONE_B: rd_word.tone.period = o_period_b;
      ADDR_TONE_C: rd_word.tone.period = o_period_c;
      ADDR_ENABLE: rd_word.lvl.level   = enable_mask;
      ADDR_VOL_A:  rd_word.lvl.level   = o_vol_a;
      ADDR_VOL_B:  rd_word.lvl.level   = o_vol_b;
      ADDR_VOL_C:  rd_word.lvl.level   = o_vol_c;
      default:     rd_word             = '0;
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (req) begin
      o_dat <= rd_word; // Held through the ack cycle
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!i_rst_n) begin
      o_ack <= 1'b0;
    end else begin
      o_ack <= req;
    end
  end

  // Tone tick divider
  assign tick_wrap = (tick_cnt == TICK_BITS'(TICK_DIV - 1));

  always_ff @(posedge sys_clk) begin
    if (!i_rst_n) begin
      tick_cnt    <= '0;
      o_tone_tick <= 1'b0;
    end else begin
      o_tone_tick <= tick_wrap;
      if (tick_wrap) begin
        tick_cnt <= '0;
      end else begin
        tick_cnt <= tick_cnt + 1'b1;
      end
    end
  end

  // DAC enable divider, every cycle when DAC_DIV is 1
  assign dac_wrap = (dac_cnt == DAC_BITS'(DAC_DIV - 1));

  always_ff @(posedge sys_clk) begin
    if (!i_rst_n) begin
      dac_cnt    <= '0;
      o_dac_tick <= 1'b0;
    end else begin
      o_dac_tick <= dac_wrap;
      if (dac_wrap) begin
        dac_cnt <= '0;
      end else begin
        dac_cnt <= dac_cnt + 1'b1;
      end
    end
  end

  // Single-cycle ack, which needs the master to drop stb in time
  a_ack_single: assert property (@(posedge sys_clk) disable iff (!i_rst_n)
    o_ack |=> !o_ack);

  a_stb_dropped: assert property (@(posedge sys_clk) disable iff (!i_rst_n)
    o_ack |-> !i_stb);

endmodule

// ==== src/psg_tone_bank.sv ====
`timescale 1ns/1ns

module psg_tone_bank (
  input  logic                                  sys_clk,
  input  logic                                  i_rst_n,
  input  logic                                  i_tone_tick,
  input  logic [psg_audio_pkg::PERIOD_BITS-1:0] i_period_a,
  input  logic [psg_audio_pkg::PERIOD_BITS-1:0] i_period_b,
  input  logic [psg_audio_pkg::PERIOD_BITS-1:0] i_period_c,
  output logic [psg_audio_pkg::NUM_CH-1:0]      o_square
);
  import psg_audio_pkg::*;

  logic [PERIOD_BITS-1:0] period [NUM_CH];

  assign period[0] = i_period_a;
  assign period[1] = i_period_b;
  assign period[2] = i_period_c;

  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch
    logic [PERIOD_BITS-1:0] count;    // Ticks spent in the current level
    logic [PERIOD_BITS-1:0] eff_period;
    logic                   wrap;
    logic                   square;

    // Period 0 behaves as 1
    assign eff_period = (period[ch] == '0) ? PERIOD_BITS'(1) : period[ch];

    // At or above, so a lowered period still wraps
    assign wrap = ({1'b0, count} + 1'b1) >= {1'b0, eff_period};

    always_ff @(posedge sys_clk) begin
      if (!i_rst_n) begin
        count  <= '0;
        square <= 1'b0;
      end else if (i_tone_tick) begin
        if (wrap) begin
          count  <= '0;
          square <= ~square;
        end else begin
          count <= count + 1'b1;
        end
      end
    end

    assign o_square[ch] = square;
  end

endmodule

// ==== src/sigma_delta_dac.sv ====
`timescale 1ns/1ns

module sigma_delta_dac (
  input  logic                               sys_clk,
  input  logic                               i_rst_n,
  input  logic                               i_dac_tick,
  input  logic [psg_audio_pkg::PCM_BITS-1:0] i_pcm,
  output logic                               o_audio
);
  import psg_audio_pkg::*;

  logic [PCM_BITS-1:0] acc;
  logic [PCM_BITS:0]   acc_sum; // Carry in the top bit

  assign acc_sum = {1'b0, acc} + {1'b0, i_pcm};

  // First-order loop: carry density equals pcm / 256
  always_ff @(posedge sys_clk) begin
    if (!i_rst_n) begin
      acc     <= '0;
      o_audio <= 1'b0;
    end else if (i_dac_tick) begin
      acc     <= acc_sum[PCM_BITS-1:0];
      o_audio <= acc_sum[PCM_BITS];
    end
  end

endmodule

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 4
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // Released just after a rising edge like the rest of the stimulus
  initial begin
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #1;
    o_rst_n = 1'b1;
  end

endmodule

// ==== tb/tb_psg_audio.sv ====
`timescale 1ns/1ns

module tb_psg_audio;
  import psg_bus_pkg::*;
  import psg_audio_pkg::*;

  localparam int TICK_DIV     = 8;
  localparam int DAC_DIV      = 2;
  localparam int MIX_CYCLES   = 1500;
  localparam int DENSITY_REPS = 4;
  // Summed test lengths in cycles, doubled for the watchdog
  localparam int TEST_CYCLES = 300 + 2 * 4 * 20 * TICK_DIV + MIX_CYCLES
                             + DENSITY_REPS * (256 * DAC_DIV + 32) + 800;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic                     sys_clk;
  logic                     rst_n;
  logic                     cyc;
  logic                     stb;
  logic                     we;
  logic [ADDR_BITS-1:0]     adr;
  logic [BUS_DATA_BITS-1:0] dat_w;
  logic [BUS_DATA_BITS-1:0] dat_r;
  logic                     ack;
  logic                     audio;
  logic [PCM_BITS-1:0]      pcm;

  // Testbench model of registers and tone state
  logic [PERIOD_BITS-1:0] m_period [NUM_CH];
  int                     m_count  [NUM_CH];
  logic [VOL_BITS-1:0]    m_vol    [NUM_CH];
  logic [VOL_BITS-1:0]    m_enable;
  logic [NUM_CH-1:0]      m_square;
  logic [PCM_BITS-1:0]    exp_pcm;
  int                     m_run;
  logic                   req_q;

  logic [31:0] lfsr = 32'h7fb3;
  string       test_name = "reset";
  int          test_errs = 0;
  int          n_pass = 0;
  int          n_fail = 0;
  int          cycle_cnt = 0;

  tb_clk_gen #(.PERIOD_NS(4), .RESET_CYCLES(4)) tb_clk_gen_i (
    .o_clk   (sys_clk),
    .o_rst_n (rst_n)
  );

  psg_audio_top psg_audio_top_i (
    .sys_clk (sys_clk),
    .i_rst_n (rst_n),
    .i_cyc   (cyc),
    .i_stb   (stb),
    .i_we    (we),
    .i_adr   (adr),
    .i_dat   (dat_w),
    .o_dat   (dat_r),
    .o_ack   (ack),
    .o_audio (audio),
    .o_pcm   (pcm)
  );

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  task automatic rand_vol(output logic [VOL_BITS-1:0] v);
    logic [31:0] r;
    rand_bits(VOL_BITS, r);
    v = VOL_BITS'(r % 15 + 1); // Never silent
  endtask

  task automatic rand_period(output int p);
    logic [31:0] r;
    rand_bits(5, r);
    p = r % 20 + 1;
  endtask

  // Expected PCM word for a given square and register state
  function automatic logic [PCM_BITS-1:0] ref_pcm(input logic [NUM_CH-1:0] sq,
      input logic [VOL_BITS-1:0] en, input logic [VOL_BITS-1:0] va,
      input logic [VOL_BITS-1:0] vb, input logic [VOL_BITS-1:0] vc);
    int sum;
    sum = 0;
    if (en[0] && sq[0]) sum += va;
    if (en[1] && sq[1]) sum += vb;
    if (en[2] && sq[2]) sum += vc;
    return PCM_BITS'(sum * 4);
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected == actual) else begin
      test_errs++;
      $display("Mismatch %s %s: expected 0x%0h, actual 0x%0h", test_name, what,
               expected, actual);
    end
  endtask

  task automatic access_reg(input logic wr, input logic [ADDR_BITS-1:0] a,
                            input logic [BUS_DATA_BITS-1:0] d,
                            output logic [BUS_DATA_BITS-1:0] q);
    int waited;
    waited = 0;
    @(posedge sys_clk);
    #1;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = wr;
    adr   = a;
    dat_w = d;
    do begin
      @(posedge sys_clk);
      #1;
      waited++;
    end while (!ack && waited < 2);
    assert (ack) else begin
      test_errs++;
      $display("Test %s: no acknowledge within 2 cycles at address %0d", test_name, a);
    end
    q   = dat_r;
    cyc = 1'b0; // Dropped inside the ack cycle
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic write_reg(input logic [ADDR_BITS-1:0] a, input logic [BUS_DATA_BITS-1:0] d);
    logic [BUS_DATA_BITS-1:0] unused;
    access_reg(1'b1, a, d, unused);
  endtask

  task automatic read_reg(input logic [ADDR_BITS-1:0] a, output logic [BUS_DATA_BITS-1:0] q);
    access_reg(1'b0, a, '0, q);
  endtask

  task automatic wait_level(input logic high);
    do @(negedge sys_clk); while ((pcm != 0) != high);
  endtask

  // Counts cycles of the current level, ends on the first cycle of the next
  task automatic measure_run(input logic high, output int len);
    len = 0;
    do begin
      len++;
      @(negedge sys_clk);
    end while ((pcm != 0) == high);
  endtask

  task automatic check_tone(input int period, input logic [VOL_BITS-1:0] vol);
    int low_len;
    int high_len;
    int eff;
    eff = (period == 0) ? 1 : period;
    write_reg(ADDR_ENABLE, 32'h0);
    write_reg(ADDR_TONE_A, period);
    write_reg(ADDR_VOL_A, vol);
    write_reg(ADDR_ENABLE, 32'h1);
    wait_level(1'b1);
    wait_level(1'b0); // First high run may be cut short by the enable
    measure_run(1'b0, low_len);
    check_value("high level", vol * 4, pcm);
    measure_run(1'b1, high_len);
    check_value("low run", eff * TICK_DIV, low_len);
    check_value("high run", eff * TICK_DIV, high_len);
  endtask

  task automatic finish_test();
    if (test_errs == 0) begin
      n_pass++;
      $display("Test %-9s ok", test_name);
    end else begin
      n_fail++;
      $display("Test %-9s %0d errors", test_name, test_errs);
    end
    test_errs = 0;
  endtask

  // Model steps on the same edges as the DUT, inputs are stable here
  always @(posedge sys_clk) begin
    int eff;
    if (!rst_n) begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        m_period[ch] = '0;
        m_count[ch]  = 0;
        m_vol[ch]    = '0;
      end
      m_enable = '0;
      m_square = '0;
      exp_pcm  = '0;
      m_run    = 0;
    end else begin
      exp_pcm = ref_pcm(m_square, m_enable, m_vol[0], m_vol[1], m_vol[2]);
      // Registered tick pulse, first one TICK_DIV cycles after reset
      if (m_run > 0 && m_run % TICK_DIV == 0) begin
        for (int ch = 0; ch < NUM_CH; ch++) begin
          eff = (m_period[ch] == 0) ? 1 : m_period[ch];
          if (m_count[ch] + 1 >= eff) begin
            m_count[ch]  = 0;
            m_square[ch] = ~m_square[ch];
          end else begin
            m_count[ch]++;
          end
        end
      end
      if (cyc && stb && we) begin
        case (adr)
          ADDR_TONE_A: m_period[0] = dat_w[PERIOD_BITS-1:0];
          ADDR_TONE_B: m_period[1] = dat_w[PERIOD_BITS-1:0];
          ADDR_TONE_C: m_period[2] = dat_w[PERIOD_BITS-1:0];
          ADDR_ENABLE: m_enable    = dat_w[VOL_BITS-1:0];
          ADDR_VOL_A:  m_vol[0]    = dat_w[VOL_BITS-1:0];
          ADDR_VOL_B:  m_vol[1]    = dat_w[VOL_BITS-1:0];
          ADDR_VOL_C:  m_vol[2]    = dat_w[VOL_BITS-1:0];
          default: ;
        endcase
      end
      m_run++;
    end
  end

  always @(posedge sys_clk) begin
    req_q <= cyc && stb;
  end

  always @(negedge sys_clk) begin
    if (rst_n) begin
      assert (pcm == exp_pcm) else begin
        test_errs++;
        $display("Mismatch %s pcm: expected %0d, actual %0d", test_name, exp_pcm, pcm);
      end
      assert (!ack || req_q) else begin
        test_errs++;
        $display("Test %s: acknowledge raised without a request", test_name);
      end
    end
  end

  always @(posedge sys_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run still going after %0d cycles", cycle_cnt);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    logic [BUS_DATA_BITS-1:0] q;
    logic [BUS_DATA_BITS-1:0] v;
    logic [BUS_DATA_BITS-1:0] expv;
    logic [BUS_DATA_BITS-1:0] written [8];
    logic [VOL_BITS-1:0]      va;
    logic [VOL_BITS-1:0]      vb;
    logic [VOL_BITS-1:0]      vc;
    int                       pa;
    int                       pb;
    int                       pc;
    int                       tries;
    int                       count;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_w = '0;
    wait (rst_n === 1'b1);
    @(negedge sys_clk);

    check_value("ack", 0, ack);
    check_value("audio", 0, audio);
    check_value("pcm", 0, pcm);
    for (int a = 0; a < 7; a++) begin
      read_reg(ADDR_BITS'(a), q);
      check_value("register after reset", 0, q);
    end
    finish_test();

    test_name = "readback";
    for (int a = 0; a < 8; a++) begin
      rand_bits(32, v);
      written[a] = v;
      write_reg(ADDR_BITS'(a), v);
    end
    for (int a = 0; a < 8; a++) begin
      read_reg(ADDR_BITS'(a), q);
      if (a < 3) expv = written[a] & ((1 << PERIOD_BITS) - 1); // Tone periods
      else if (a < 7) expv = written[a] & ((1 << VOL_BITS) - 1);
      else expv = '0; // Unmapped
      check_value("register read", expv, q);
    end
    finish_test();

    test_name = "tone";
    rand_period(pa);
    rand_vol(va);
    check_tone(pa, va);
    rand_vol(va);
    check_tone(0, va);
    finish_test();

    test_name = "mix";
    rand_vol(va);
    rand_vol(vb);
    rand_vol(vc);
    rand_period(pa);
    rand_period(pb);
    rand_period(pc);
    pb = pa + pb; // Strictly increasing so all distinct
    pc = pb + pc;
    write_reg(ADDR_VOL_A, va);
    write_reg(ADDR_VOL_B, vb);
    write_reg(ADDR_VOL_C, vc);
    write_reg(ADDR_TONE_A, pa);
    write_reg(ADDR_TONE_B, pb);
    write_reg(ADDR_TONE_C, pc);
    write_reg(ADDR_ENABLE, 32'h7);
    repeat (MIX_CYCLES) @(posedge sys_clk);
    finish_test();

    test_name = "density";
    write_reg(ADDR_TONE_A, 32'hfff);
    write_reg(ADDR_TONE_B, 32'hfff);
    write_reg(ADDR_TONE_C, 32'hfff);
    tries = 0;
    // Let channel A flip until some square bit is parked high
    while (m_square == '0 && tries < 8) begin
      write_reg(ADDR_TONE_A, 32'h1);
      repeat (TICK_DIV) @(posedge sys_clk);
      write_reg(ADDR_TONE_A, 32'hfff);
      tries++;
    end
    assert (m_square != '0) else begin
      test_errs++;
      $display("Test %s: every channel stayed low, no level to measure", test_name);
    end
    write_reg(ADDR_ENABLE, 32'h7);
    for (int r = 0; r < DENSITY_REPS; r++) begin
      rand_vol(va);
      rand_vol(vb);
      rand_vol(vc);
      write_reg(ADDR_VOL_A, va);
      write_reg(ADDR_VOL_B, vb);
      write_reg(ADDR_VOL_C, vc);
      repeat (4) @(posedge sys_clk);
      expv  = ref_pcm(m_square, 4'h7, va, vb, vc);
      count = 0;
      for (int s = 0; s < 256; s++) begin
        repeat (DAC_DIV) @(negedge sys_clk); // One sample per DAC update
        count += audio;
      end
      check_value("audio ones", expv, count);
    end
    finish_test();

    test_name = "disable";
    write_reg(ADDR_ENABLE, 32'h0);
    @(posedge sys_clk);
    @(negedge sys_clk);
    check_value("pcm after disable", 0, pcm);
    repeat (4) @(posedge sys_clk);
    count = 0;
    repeat (512) begin
      @(negedge sys_clk);
      count += audio;
    end
    check_value("audio high cycles", 0, count);
    finish_test();

    $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
